//--- hpdc_mem_pkg.sv
// Cache-side memory interface types: requests, write data, responses and invalidations
package hpdc_mem_pkg;

    localparam int unsigned MEM_DATA_W    = 128;
    localparam int unsigned MEM_BE_W      = MEM_DATA_W / 8;
    localparam int unsigned BE_IDX_W      = $clog2(MEM_BE_W); // Byte index within a beat
    localparam int unsigned PA_W          = 40;
    localparam int unsigned MEM_ID_W      = 4;
    localparam int unsigned PORT_ID_W     = 3;
    localparam int unsigned LINE_OFFSET_W = 4;  // 16-byte lines for invalidation

    // Request size code, log2 of the byte count
    localparam logic [2:0] MEM_SIZE_16B = 3'd4;

    typedef enum logic [2:0] {
        IFILL     = 3'd0,
        READ      = 3'd1,
        WRITE     = 3'd2,
        UNC_READ  = 3'd3,
        UNC_WRITE = 3'd4
    } hpdc_req_class_e;

    typedef struct packed {
        logic [PA_W-1:0]     addr;
        logic [2:0]          size;
        logic [MEM_ID_W-1:0] id;
        hpdc_req_class_e     req_class;
        logic                cacheable;
    } hpdc_mem_req_t;

    typedef struct packed {
        logic [MEM_DATA_W-1:0] data;
        logic [MEM_BE_W-1:0]   be;
    } hpdc_mem_wdata_t;

    typedef struct packed {
        logic                  error;
        logic [MEM_ID_W-1:0]   id;
        logic [MEM_DATA_W-1:0] data;
    } hpdc_mem_resp_t;

    // Line-aligned address of a line to drop from the data cache
    typedef struct packed {
        logic [PA_W-1:0] addr;
    } hpdc_inval_t;

endpackage

//--- l15_pkg.sv
// L1.5 port types: request and return words, type codes and thread-id constants
package l15_pkg;

    localparam int unsigned L15_TID_W        = 2;
    localparam int unsigned NUM_TIDS         = 2 ** L15_TID_W;
    localparam int unsigned INVAL_FIFO_DEPTH = 4;
    localparam int unsigned INVAL_PTR_W      = $clog2(INVAL_FIFO_DEPTH);
    localparam int unsigned L15_ADDR_W       = 40;
    localparam int unsigned L15_DATA_W       = 64;
    localparam int unsigned L15_RTRN_DATA_W  = 128;

    typedef enum logic [4:0] {
        LOAD  = 5'b00000,
        STORE = 5'b00001,
        IMISS = 5'b10000
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        LOAD_RET  = 4'b0000,
        IFILL_RET = 4'b0001,
        EVICT_REQ = 4'b0011,
        ST_ACK    = 4'b0100,
        ERR_RET   = 4'b1100
    } l15_rettype_e;

    localparam logic [2:0] L15_SIZE_1B       = 3'b000;
    localparam logic [2:0] L15_SIZE_2B       = 3'b001;
    localparam logic [2:0] L15_SIZE_4B       = 3'b010;
    localparam logic [2:0] L15_SIZE_8B       = 3'b011;
    localparam logic [2:0] L15_SIZE_LINE     = 3'b111; // 16B on loads, 32B on fills
    localparam logic [2:0] L15_SIZE_IFILL_NC = L15_SIZE_4B;

    typedef logic [L15_TID_W-1:0] l15_tid_t;

    typedef struct packed {
        logic                  val;
        l15_rqtype_e           rqtype;
        logic                  nc;
        logic [2:0]            size;
        l15_tid_t              threadid;
        logic [L15_ADDR_W-1:0] address;
        logic [L15_DATA_W-1:0] data;
    } l15_req_t;

    typedef struct packed {
        logic                       val;
        logic                       header_ack;
        logic                       ack;
        l15_rettype_e               returntype;
        l15_tid_t                   threadid;
        logic [L15_RTRN_DATA_W-1:0] data;
        logic                       inval_dcache;
        logic [L15_ADDR_W-1:0]      transducer_address;
    } l15_rtrn_t;

endpackage

//--- l15_req_encoder.sv
`timescale 1ns/1ps
// L1.5 request encoder: classifies and sizes cache requests and runs the header_ack/ack handshake
module l15_req_encoder (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               req_valid_i,
    input  hpdc_mem_pkg::hpdc_mem_req_t        req_i,
    input  hpdc_mem_pkg::hpdc_mem_wdata_t      req_wdata_i,
    input  logic [hpdc_mem_pkg::PORT_ID_W-1:0] req_pid_i,
    output logic                               req_ready_o,
    input  l15_pkg::l15_rtrn_t                 l15_rtrn_i,
    output l15_pkg::l15_req_t                  l15_req_o,
    input  logic                               free_tid_valid_i,
    input  l15_pkg::l15_tid_t                  free_tid_i,
    output logic                               grant_o,
    output l15_pkg::l15_tid_t                  grant_tid_o,
    output logic [hpdc_mem_pkg::MEM_ID_W-1:0]  grant_id_o,
    output logic [hpdc_mem_pkg::PORT_ID_W-1:0] grant_pid_o
);
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HDR_ACK,
        WAIT_ACK
    } state_e;

    state_e                state_q, state_d;
    logic                  req_val;
    logic [BE_IDX_W:0]     be_count;
    logic [BE_IDX_W-1:0]   hi_byte;
    logic [BE_IDX_W-1:0]   lo_byte;
    logic [2:0]            st_size;
    logic [PA_W-1:0]       st_addr;
    logic [L15_DATA_W-1:0] lane_data;
    logic [L15_DATA_W-1:0] rep_data;

    // Byte-enable population count and highest enabled byte
    always_comb begin
        be_count = '0;
        hi_byte  = '0;
        for (int i = 0; i < MEM_BE_W; i++) begin
            be_count = be_count + (BE_IDX_W + 1)'(req_wdata_i.be[i]);
            if (req_wdata_i.be[i]) begin
                hi_byte = BE_IDX_W'(i);
            end
        end
    end

    // Enabled bytes form one contiguous run
    assign lo_byte   = hi_byte - be_count[BE_IDX_W-1:0] + 1'b1;
    assign lane_data = lo_byte[3] ? req_wdata_i.data[127:64] : req_wdata_i.data[63:0];

    always_comb begin
        st_addr = {req_i.addr[PA_W-1:3], lo_byte[2:0]}; // Aligned to the run
        case (be_count)
            5'd1: st_size = L15_SIZE_1B;
            5'd2: st_size = L15_SIZE_2B;
            5'd4: st_size = L15_SIZE_4B;
            5'd8: begin
                st_size = L15_SIZE_8B;
                st_addr = req_i.addr;
            end
            default: begin
                st_size = L15_SIZE_LINE;
                st_addr = req_i.addr;
            end
        endcase
    end

    // Narrow uncached stores carry their bytes in every lane position
    always_comb begin
        case (st_size)
            L15_SIZE_1B: rep_data = {8{lane_data[{lo_byte[2:0], 3'b000} +: 8]}};
            L15_SIZE_2B: rep_data = {4{lane_data[{lo_byte[2:0], 3'b000} +: 16]}};
            L15_SIZE_4B: rep_data = {2{lane_data[{lo_byte[2:0], 3'b000} +: 32]}};
            default:     rep_data = lane_data;
        endcase
    end

    always_comb begin
        l15_req_o.val      = req_val;
        l15_req_o.nc       = ~req_i.cacheable;
        l15_req_o.threadid = free_tid_i;
        l15_req_o.address  = req_i.addr;
        l15_req_o.data     = (req_i.req_class == UNC_WRITE) ? rep_data : lane_data;
        case (req_i.req_class)
            IFILL: begin
                l15_req_o.rqtype = IMISS;
                l15_req_o.size   = req_i.cacheable ? L15_SIZE_LINE : L15_SIZE_IFILL_NC;
            end
            READ, UNC_READ: begin
                l15_req_o.rqtype = LOAD;
                l15_req_o.size   = (req_i.size == MEM_SIZE_16B) ? L15_SIZE_LINE : req_i.size;
            end
            default: begin // Cached and uncached stores
                l15_req_o.rqtype  = STORE;
                l15_req_o.size    = st_size;
                l15_req_o.address = st_addr;
            end
        endcase
    end

    // Handshake FSM, val drops while waiting for ack
    always_comb begin
        state_d     = state_q;
        req_val     = 1'b0;
        req_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && free_tid_valid_i) begin
                    req_val = 1'b1;
                    if (!l15_rtrn_i.header_ack) begin
                        state_d = WAIT_HDR_ACK;
                    end else if (l15_rtrn_i.ack) begin
                        req_ready_o = 1'b1;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_HDR_ACK: begin
                req_val = 1'b1;
                if (l15_rtrn_i.header_ack) begin
                    if (l15_rtrn_i.ack) begin
                        req_ready_o = 1'b1;
                        state_d     = IDLE;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_ACK: begin
                if (l15_rtrn_i.ack) begin
                    req_ready_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign grant_o     = req_ready_o; // Request accepted by the L1.5
    assign grant_tid_o = free_tid_i;
    assign grant_id_o  = req_i.id;
    assign grant_pid_o = req_pid_i;

endmodule

//--- l15_thread_table.sv
`timescale 1ns/1ps
// Thread-id table: free list of L1.5 thread ids and the request and port id held per id
module l15_thread_table (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               grant_i,
    input  l15_pkg::l15_tid_t                  grant_tid_i,
    input  logic [hpdc_mem_pkg::MEM_ID_W-1:0]  grant_id_i,
    input  logic [hpdc_mem_pkg::PORT_ID_W-1:0] grant_pid_i,
    input  logic                               release_i,
    input  l15_pkg::l15_tid_t                  release_tid_i,
    output logic                               free_tid_valid_o,
    output l15_pkg::l15_tid_t                  free_tid_o,
    input  l15_pkg::l15_tid_t                  lookup_tid_i,
    output logic [hpdc_mem_pkg::MEM_ID_W-1:0]  lookup_id_o,
    output logic [hpdc_mem_pkg::PORT_ID_W-1:0] lookup_pid_o
);
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    l15_tid_t             free_list_q [NUM_TIDS];
    l15_tid_t             rd_ptr_q;
    l15_tid_t             wr_ptr_q;
    logic [L15_TID_W:0]   free_cnt_q;
    logic [MEM_ID_W-1:0]  id_tab_q  [NUM_TIDS];
    logic [PORT_ID_W-1:0] pid_tab_q [NUM_TIDS];

    assign free_tid_valid_o = (free_cnt_q != '0);
    assign free_tid_o       = free_list_q[rd_ptr_q];

    // Circular free list, pointers wrap at NUM_TIDS
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_TIDS; i++) begin
                free_list_q[i] <= l15_tid_t'(i);
            end
            rd_ptr_q   <= '0;
            wr_ptr_q   <= '0;
            free_cnt_q <= (L15_TID_W + 1)'(NUM_TIDS);
        end else begin
            if (grant_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (release_i) begin
                free_list_q[wr_ptr_q] <= release_tid_i;
                wr_ptr_q              <= wr_ptr_q + 1'b1;
            end
            case ({grant_i, release_i})
                2'b10:   free_cnt_q <= free_cnt_q - 1'b1;
                2'b01:   free_cnt_q <= free_cnt_q + 1'b1;
                default: free_cnt_q <= free_cnt_q;
            endcase
        end
    end

    // Ids recorded at grant, read back by the return path
    always_ff @(posedge clk_i) begin
        if (grant_i) begin
            id_tab_q[grant_tid_i]  <= grant_id_i;
            pid_tab_q[grant_tid_i] <= grant_pid_i;
        end
    end

    assign lookup_id_o  = id_tab_q[lookup_tid_i];
    assign lookup_pid_o = pid_tab_q[lookup_tid_i];

endmodule

//--- l15_inval_fifo.sv
`timescale 1ns/1ps
// Invalidation FIFO holding data-cache line invalidations until the cache takes them
module l15_inval_fifo (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      push_i,
    input  hpdc_mem_pkg::hpdc_inval_t inval_i,
    output logic                      full_o,
    output logic                      inval_valid_o,
    input  logic                      inval_ready_i,
    output hpdc_mem_pkg::hpdc_inval_t inval_o
);
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    localparam logic [INVAL_PTR_W-1:0] LAST = INVAL_PTR_W'(INVAL_FIFO_DEPTH - 1);

    hpdc_inval_t            mem_q [INVAL_FIFO_DEPTH];
    logic [INVAL_PTR_W-1:0] rd_ptr_q;
    logic [INVAL_PTR_W-1:0] wr_ptr_q;
    logic [INVAL_PTR_W:0]   count_q;
    logic                   pop;

    assign full_o        = (count_q == (INVAL_PTR_W + 1)'(INVAL_FIFO_DEPTH));
    assign inval_valid_o = (count_q != '0);
    assign inval_o       = mem_q[rd_ptr_q];
    assign pop           = inval_valid_o & inval_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == LAST) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == LAST) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push_i, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= inval_i; // Decoder never pushes when full
        end
    end

endmodule

//--- l15_resp_decoder.sv
`timescale 1ns/1ps
// L1.5 return decoder: builds cache responses and invalidations and acknowledges the return
module l15_resp_decoder (
    input  l15_pkg::l15_rtrn_t                 l15_rtrn_i,
    input  logic                               resp_ready_i,
    output logic                               resp_valid_o,
    output hpdc_mem_pkg::hpdc_mem_resp_t       resp_o,
    output logic [hpdc_mem_pkg::PORT_ID_W-1:0] resp_pid_o,
    output logic                               l15_req_ack_o,
    output logic                               release_o,
    output l15_pkg::l15_tid_t                  release_tid_o,
    output logic                               inval_push_o,
    output hpdc_mem_pkg::hpdc_inval_t          inval_o,
    input  logic                               inval_full_i,
    output l15_pkg::l15_tid_t                  lookup_tid_o,
    input  logic [hpdc_mem_pkg::MEM_ID_W-1:0]  lookup_id_i,
    input  logic [hpdc_mem_pkg::PORT_ID_W-1:0] lookup_pid_i
);
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    logic is_evict;
    logic inval_ok;

    assign is_evict = (l15_rtrn_i.returntype == EVICT_REQ); // Invalidation only
    assign inval_ok = ~l15_rtrn_i.inval_dcache | ~inval_full_i;

    assign resp_valid_o  = l15_rtrn_i.val & ~is_evict & inval_ok;
    assign l15_req_ack_o = is_evict ? l15_rtrn_i.val & ~inval_full_i
                                    : l15_rtrn_i.val & resp_ready_i & inval_ok;

    // Thread id goes back once its response is taken
    assign release_o     = l15_req_ack_o & ~is_evict;
    assign release_tid_o = l15_rtrn_i.threadid;
    assign lookup_tid_o  = l15_rtrn_i.threadid;

    assign resp_o.error = (l15_rtrn_i.returntype == ERR_RET);
    assign resp_o.id    = lookup_id_i;
    assign resp_o.data  = l15_rtrn_i.data;
    assign resp_pid_o   = lookup_pid_i;

    assign inval_push_o = l15_req_ack_o & (is_evict | l15_rtrn_i.inval_dcache);
    assign inval_o.addr = {l15_rtrn_i.transducer_address[PA_W-1:LINE_OFFSET_W],
                           {LINE_OFFSET_W{1'b0}}};

endmodule

//--- hpdc_l15_adapter.sv
`timescale 1ns/1ps
// Data cache to L1.5 adapter: request encoder, thread table, invalidation FIFO and return decoder
module hpdc_l15_adapter (
    input  logic                               clk_i,
    input  logic                               rst_ni,
    input  logic                               req_valid_i,
    input  hpdc_mem_pkg::hpdc_mem_req_t        req_i,
    input  hpdc_mem_pkg::hpdc_mem_wdata_t      req_wdata_i,
    input  logic [hpdc_mem_pkg::PORT_ID_W-1:0] req_pid_i,
    output logic                               req_ready_o,
    output l15_pkg::l15_req_t                  l15_req_o,
    output logic                               l15_req_ack_o,
    input  l15_pkg::l15_rtrn_t                 l15_rtrn_i,
    input  logic                               resp_ready_i,
    output logic                               resp_valid_o,
    output hpdc_mem_pkg::hpdc_mem_resp_t       resp_o,
    output logic [hpdc_mem_pkg::PORT_ID_W-1:0] resp_pid_o,
    input  logic                               inval_ready_i,
    output logic                               inval_valid_o,
    output hpdc_mem_pkg::hpdc_inval_t          inval_req_o
);
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    logic                 free_tid_valid;
    l15_tid_t             free_tid;
    logic                 grant;
    l15_tid_t             grant_tid;
    logic [MEM_ID_W-1:0]  grant_id;
    logic [PORT_ID_W-1:0] grant_pid;
    logic                 rel;
    l15_tid_t             release_tid;
    l15_tid_t             lookup_tid;
    logic [MEM_ID_W-1:0]  lookup_id;
    logic [PORT_ID_W-1:0] lookup_pid;
    logic                 inval_push;
    logic                 inval_full;
    hpdc_inval_t          inval;

    l15_req_encoder i_l15_req_encoder (
        .clk_i,
        .rst_ni,
        .req_valid_i,
        .req_i,
        .req_wdata_i,
        .req_pid_i,
        .req_ready_o,
        .l15_rtrn_i,
        .l15_req_o,
        .free_tid_valid_i (free_tid_valid),
        .free_tid_i       (free_tid),
        .grant_o          (grant),
        .grant_tid_o      (grant_tid),
        .grant_id_o       (grant_id),
        .grant_pid_o      (grant_pid)
    );

    l15_thread_table i_l15_thread_table (
        .clk_i,
        .rst_ni,
        .grant_i          (grant),
        .grant_tid_i      (grant_tid),
        .grant_id_i       (grant_id),
        .grant_pid_i      (grant_pid),
        .release_i        (rel),
        .release_tid_i    (release_tid),
        .free_tid_valid_o (free_tid_valid),
        .free_tid_o       (free_tid),
        .lookup_tid_i     (lookup_tid),
        .lookup_id_o      (lookup_id),
        .lookup_pid_o     (lookup_pid)
    );

    l15_inval_fifo i_l15_inval_fifo (
        .clk_i,
        .rst_ni,
        .push_i        (inval_push),
        .inval_i       (inval),
        .full_o        (inval_full),
        .inval_valid_o,
        .inval_ready_i,
        .inval_o       (inval_req_o)
    );

    l15_resp_decoder i_l15_resp_decoder (
        .l15_rtrn_i,
        .resp_ready_i,
        .resp_valid_o,
        .resp_o,
        .resp_pid_o,
        .l15_req_ack_o,
        .release_o     (rel),
        .release_tid_o (release_tid),
        .inval_push_o  (inval_push),
        .inval_o       (inval),
        .inval_full_i  (inval_full),
        .lookup_tid_o  (lookup_tid),
        .lookup_id_i   (lookup_id),
        .lookup_pid_i  (lookup_pid)
    );

endmodule

//--- tb_hpdc_l15_adapter.sv
`timescale 1ns/1ps
// Testbench for the data cache to L1.5 adapter with an L1.5 model and reference checks
module tb_hpdc_l15_adapter;
    import hpdc_mem_pkg::*;
    import l15_pkg::*;

    localparam int unsigned NUM_TXN    = 240;
    localparam int unsigned MAX_CYCLES = 12000; // 240 transactions, 50 cycles each at most
    localparam int unsigned SEED       = 32'hd3a0_ec46;
    localparam int          PH_IDLE    = 0;
    localparam int          PH_HDR     = 1;     // Waiting for header_ack
    localparam int          PH_ACK     = 2;     // Waiting for ack

    logic                 clk_i;
    logic                 rst_ni;
    logic                 req_valid;
    hpdc_mem_req_t        req;
    hpdc_mem_wdata_t      wdata;
    logic [PORT_ID_W-1:0] req_pid;
    logic                 req_ready;
    l15_req_t             l15_req;
    logic                 l15_req_ack;
    l15_rtrn_t            l15_rtrn;
    logic                 resp_ready;
    logic                 resp_valid;
    hpdc_mem_resp_t       resp;
    logic [PORT_ID_W-1:0] resp_pid;
    logic                 inval_ready;
    logic                 inval_valid;
    hpdc_inval_t          inval_req;

    // L1.5 model state
    int                   hs_phase    = PH_IDLE;
    int                   hdr_wait    = 0;
    int                   ack_wait    = 0;
    int                   n_accepted  = 0;
    int                   cycle       = 0;
    int                   tid_stalls  = 0;
    int                   full_stalls = 0;
    logic                 ret_taken   = 1'b0;
    logic                 inval_hold  = 1'b0;
    l15_tid_t             free_q [$];
    l15_tid_t             pend_q [$]; // Granted, no return yet
    hpdc_inval_t          inv_q  [$];
    logic [MEM_ID_W-1:0]  out_id    [NUM_TIDS];
    logic [PORT_ID_W-1:0] out_pid   [NUM_TIDS];
    hpdc_req_class_e      out_class [NUM_TIDS];

    hpdc_l15_adapter i_hpdc_l15_adapter (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_valid_i   (req_valid),
        .req_i         (req),
        .req_wdata_i   (wdata),
        .req_pid_i     (req_pid),
        .req_ready_o   (req_ready),
        .l15_req_o     (l15_req),
        .l15_req_ack_o (l15_req_ack),
        .l15_rtrn_i    (l15_rtrn),
        .resp_ready_i  (resp_ready),
        .resp_valid_o  (resp_valid),
        .resp_o        (resp),
        .resp_pid_o    (resp_pid),
        .inval_ready_i (inval_ready),
        .inval_valid_o (inval_valid),
        .inval_req_o   (inval_req)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            abort_run("Handshake flag mismatch");
        end
    endtask

    task automatic check_l15_req(input l15_req_t got, input l15_req_t exp);
        if (got !== exp) begin
            $display("ERR %0t l15_req_o got %h expected %h", $time, got, exp);
            abort_run("L1.5 request mismatch");
        end
    endtask

    task automatic check_resp(input hpdc_mem_resp_t got, input logic [PORT_ID_W-1:0] got_pid,
                              input hpdc_mem_resp_t exp, input logic [PORT_ID_W-1:0] exp_pid);
        if (got !== exp || got_pid !== exp_pid) begin
            $display("ERR %0t resp_o got %h expected %h", $time, got, exp);
            $display("ERR %0t resp_pid_o got %h expected %h", $time, got_pid, exp_pid);
            abort_run("Cache response mismatch");
        end
    endtask

    task automatic check_inval(input hpdc_inval_t got, input hpdc_inval_t exp);
        if (got !== exp) begin
            $display("ERR %0t inval_req_o got %h expected %h", $time, got, exp);
            abort_run("Invalidation mismatch");
        end
    endtask

    // Expected L1.5 request for a cache request offered with thread id tid
    function automatic l15_req_t expected_l15_req(input hpdc_mem_req_t r,
                                                  input hpdc_mem_wdata_t w, input l15_tid_t tid);
        l15_req_t e;
        int       n;
        int       lo;
        int       m;
        n  = 0;
        lo = -1;
        for (int b = 0; b < MEM_BE_W; b++) begin
            if (w.be[b]) begin
                n++;
                if (lo < 0) begin
                    lo = b;
                end
            end
        end
        lo = (lo < 0) ? 0 : lo;
        m  = (n == 1 || n == 2 || n == 4) ? n : 8; // Replication period in bytes
        e.val      = 1'b1;
        e.nc       = ~r.cacheable;
        e.threadid = tid;
        e.address  = r.addr;
        for (int k = 0; k < 8; k++) begin
            if (r.req_class == UNC_WRITE) begin
                e.data[k*8 +: 8] = w.data[(lo + (k % m)) * 8 +: 8];
            end else begin
                e.data[k*8 +: 8] = w.data[((lo & 8) + k) * 8 +: 8]; // Lane of lowest byte
            end
        end
        case (r.req_class)
            IFILL: begin
                e.rqtype = IMISS;
                e.size   = r.cacheable ? L15_SIZE_LINE : L15_SIZE_IFILL_NC;
            end
            READ, UNC_READ: begin
                e.rqtype = LOAD;
                e.size   = (r.size == MEM_SIZE_16B) ? L15_SIZE_LINE : r.size;
            end
            default: begin
                e.rqtype = STORE;
                case (n)
                    1:       e.size = L15_SIZE_1B;
                    2:       e.size = L15_SIZE_2B;
                    4:       e.size = L15_SIZE_4B;
                    8:       e.size = L15_SIZE_8B;
                    default: e.size = L15_SIZE_LINE;
                endcase
                if (m != 8) begin
                    e.address = {r.addr[PA_W-1:3], 3'(lo)};
                end
            end
        endcase
        return e;
    endfunction

    task automatic track_request();
        l15_req_t exp;
        logic     exp_val;
        l15_tid_t tid;
        exp_val = (hs_phase == PH_HDR) || (hs_phase == PH_IDLE && req_valid && free_q.size() != 0);
        if (hs_phase == PH_IDLE && req_valid && free_q.size() == 0) begin
            tid_stalls++;
        end
        check_flag("req_ready_o", req_ready, hs_phase == PH_ACK && l15_rtrn.ack);
        if (exp_val || hs_phase == PH_ACK) begin
            exp     = expected_l15_req(req, wdata, free_q[0]);
            exp.val = exp_val; // Fields held, val low while waiting for ack
            check_l15_req(l15_req, exp);
        end else begin
            check_flag("l15_req_o.val", l15_req.val, 1'b0);
        end
        if (hs_phase == PH_IDLE && exp_val) begin
            hs_phase = PH_HDR;
            hdr_wait = $urandom_range(0, 3);
        end else if (hs_phase == PH_HDR && l15_rtrn.header_ack) begin
            hs_phase = PH_ACK;
            ack_wait = $urandom_range(0, 3);
        end else if (hs_phase == PH_ACK && l15_rtrn.ack) begin
            tid            = free_q.pop_front();
            out_id[tid]    = req.id;
            out_pid[tid]   = req_pid;
            out_class[tid] = req.req_class;
            pend_q.push_back(tid);
            n_accepted++;
            hs_phase = PH_IDLE;
        end
    endtask

    task automatic track_return();
        hpdc_mem_resp_t exp;
        hpdc_inval_t    line;
        logic           is_evict;
        logic           room;
        logic           exp_rv;
        logic           exp_ack;
        l15_tid_t       tid;
        tid      = l15_rtrn.threadid;
        is_evict = (l15_rtrn.returntype == EVICT_REQ);
        room     = (inv_q.size() < INVAL_FIFO_DEPTH);
        exp_rv   = l15_rtrn.val && !is_evict && (room || !l15_rtrn.inval_dcache);
        exp_ack  = is_evict ? (l15_rtrn.val && room) : (exp_rv && resp_ready);
        if (l15_rtrn.val && !room && (is_evict || l15_rtrn.inval_dcache)) begin
            full_stalls++;
        end
        check_flag("resp_valid_o", resp_valid, exp_rv);
        check_flag("l15_req_ack_o", l15_req_ack, exp_ack);
        if (exp_rv) begin
            exp.error = (l15_rtrn.returntype == ERR_RET);
            exp.id    = out_id[tid];
            exp.data  = l15_rtrn.data;
            check_resp(resp, resp_pid, exp, out_pid[tid]);
        end
        check_flag("inval_valid_o", inval_valid, inv_q.size() != 0);
        if (inv_q.size() != 0) begin
            check_inval(inval_req, inv_q[0]);
            if (inval_ready) begin
                void'(inv_q.pop_front());
            end
        end
        if (exp_ack) begin
            if (is_evict || l15_rtrn.inval_dcache) begin
                line.addr                      = l15_rtrn.transducer_address;
                line.addr[LINE_OFFSET_W-1:0]   = '0; // Line aligned
                inv_q.push_back(line);
            end
            if (!is_evict) begin
                free_q.push_back(tid);
            end
            ret_taken = 1'b1;
        end
    endtask

    // Puts a new return on the L1.5 return channel, or leaves it idle
    task automatic present_return();
        int          idx;
        l15_tid_t    tid;
        logic [63:0] a;
        a                           = {$urandom, $urandom};
        l15_rtrn.transducer_address = a[L15_ADDR_W-1:0];
        l15_rtrn.data               = {$urandom, $urandom, $urandom, $urandom};
        l15_rtrn.inval_dcache       = 1'($urandom_range(0, 7) == 0);
        if ($urandom_range(0, inval_hold ? 1 : 15) == 0) begin
            l15_rtrn.val        = 1'b1;
            l15_rtrn.returntype = EVICT_REQ;
            l15_rtrn.threadid   = l15_tid_t'($urandom_range(0, NUM_TIDS - 1));
        end else if (pend_q.size() != 0 && $urandom_range(0, 2) == 0) begin
            idx = $urandom_range(0, pend_q.size() - 1); // Any outstanding id, out of order
            tid = pend_q[idx];
            pend_q.delete(idx);
            l15_rtrn.val      = 1'b1;
            l15_rtrn.threadid = tid;
            case (out_class[tid])
                IFILL:          l15_rtrn.returntype = IFILL_RET;
                READ, UNC_READ: l15_rtrn.returntype = LOAD_RET;
                default:        l15_rtrn.returntype = ST_ACK;
            endcase
            if ($urandom_range(0, 7) == 0) begin
                l15_rtrn.returntype = ERR_RET;
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle++;
        if (cycle > MAX_CYCLES) begin
            $display("Run did not finish within %0d cycles", MAX_CYCLES);
            abort_run("Timeout");
        end
    end

    // L1.5 and cache-side ready drivers
    always @(posedge clk_i) begin
        #2;
        inval_hold          = (cycle >= 400 && cycle < 600); // FIFO fills in this window
        inval_ready         = ~inval_hold & 1'($urandom_range(0, 2) != 0);
        resp_ready          = 1'($urandom_range(0, 3) != 0);
        l15_rtrn.header_ack = 1'b0;
        l15_rtrn.ack        = 1'b0;
        if (hs_phase == PH_HDR) begin
            if (hdr_wait == 0) begin
                l15_rtrn.header_ack = 1'b1;
            end else begin
                hdr_wait--;
            end
        end
        if (hs_phase == PH_ACK) begin
            if (ack_wait == 0) begin
                l15_rtrn.ack = 1'b1;
            end else begin
                ack_wait--;
            end
        end
        if (ret_taken) begin
            l15_rtrn.val = 1'b0;
            ret_taken    = 1'b0;
        end
        if (!l15_rtrn.val) begin
            present_return();
        end
    end

    always @(negedge clk_i) begin
        if (rst_ni) begin
            track_request();
            track_return();
        end
    end

    initial begin
        hpdc_mem_req_t   r;
        hpdc_mem_wdata_t w;
        logic [63:0]     a;
        int              n;
        int              off;
        int              gap;
        void'($urandom(SEED));
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        req_valid   = 1'b0;
        req         = '0;
        wdata       = '0;
        req_pid     = '0;
        l15_rtrn    = '0;
        resp_ready  = 1'b0;
        inval_ready = 1'b0;
        for (int t = 0; t < NUM_TIDS; t++) begin
            free_q.push_back(l15_tid_t'(t));
        end
        repeat (5) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        for (int i = 0; i < NUM_TXN; i++) begin
            a           = {$urandom, $urandom};
            r.addr      = a[PA_W-1:0];
            r.req_class = hpdc_req_class_e'(3'($urandom_range(0, 4)));
            r.cacheable = 1'($urandom_range(0, 1));
            r.size      = 3'($urandom_range(0, 4));
            r.id        = MEM_ID_W'($urandom);
            w.data      = {$urandom, $urandom, $urandom, $urandom};
            w.be        = '0;
            if (r.req_class == WRITE || r.req_class == UNC_WRITE) begin
                n    = 1 << $urandom_range(0, 4); // Aligned run of 1 to 16 bytes
                off  = n * int'($urandom_range(0, MEM_BE_W / n - 1));
                w.be = MEM_BE_W'(((32'd1 << n) - 1) << off);
            end
            req       = r;
            wdata     = w;
            req_pid   = PORT_ID_W'($urandom);
            req_valid = 1'b1;
            while (n_accepted != i + 1) begin
                @(posedge clk_i);
            end
            #2;
            req_valid = 1'b0;
            gap       = $urandom_range(0, 2);
            repeat (gap) begin
                @(posedge clk_i);
                #2;
            end
        end
        while (free_q.size() != NUM_TIDS || inv_q.size() != 0 || l15_rtrn.val) begin
            @(posedge clk_i);
        end
        if (tid_stalls == 0 || full_stalls == 0) begin
            $display("Thread-id exhaustion or a full invalidation FIFO was never reached");
            abort_run("Missing stall coverage");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- filelist.f
hpdc_mem_pkg.sv
l15_pkg.sv
l15_req_encoder.sv
l15_thread_table.sv
l15_inval_fifo.sv
l15_resp_decoder.sv
hpdc_l15_adapter.sv
tb_hpdc_l15_adapter.sv

//--- Bender.yml
package:
  name: hpdc_l15_adapter

sources:
  - hpdc_mem_pkg.sv
  - l15_pkg.sv
  - l15_req_encoder.sv
  - l15_thread_table.sv
  - l15_inval_fifo.sv
  - l15_resp_decoder.sv
  - hpdc_l15_adapter.sv
  - target: test
    files:
      - tb_hpdc_l15_adapter.sv
